// ==== Bender.yml ====
package:
  name: alu_unit

sources:
  # Packages ahead of the modules that import them
  - src/rvIsaPkg.sv
  - src/aluUnitPkg.sv
  - src/instrDecoder.sv
  - src/aluDecoder.sv
  - src/aluExecute.sv
  - src/resultStage.sv
  - src/aluUnit.sv
  - target: test
    files:
      - testbench/clockGen.sv
      - testbench/aluUnitTb.sv

// ==== all.f ====
src/rvIsaPkg.sv
src/aluUnitPkg.sv
src/instrDecoder.sv
src/aluDecoder.sv
src/aluExecute.sv
src/resultStage.sv
src/aluUnit.sv
testbench/clockGen.sv
testbench/aluUnitTb.sv

// ==== src/aluDecoder.sv ====
`timescale 1ns/1ps

module aluDecoder (
    input  aluUnitPkg::decodedInstrT decoded,
    output aluUnitPkg::aluCtrlT      aluCtrl
);

    import rvIsaPkg::*;
    import aluUnitPkg::*;

    always_comb begin
        case (decoded.aluOp)
            aluOpAdd: aluCtrl = ctrlAdd;   // Loads and stores
            aluOpSub: aluCtrl = ctrlSub;   // Branch compare

            // OP and OP-IMM
            aluOpFunct: begin
                case (decoded.funct3)
                    f3Slt:  aluCtrl = ctrlSlt;
                    f3Sltu: aluCtrl = ctrlSltu;
                    f3Or:   aluCtrl = ctrlOr;
                    f3Xor:  aluCtrl = ctrlXor;
                    f3And:  aluCtrl = ctrlAnd;
                    f3Sll:  aluCtrl = ctrlSll;

                    f3AddSub: begin
                        // Sub only for OP, never ADDI
                        if (decoded.op5 && decoded.funct7b5) begin
                            aluCtrl = ctrlSub;
                        end else begin
                            aluCtrl = ctrlAdd;
                        end
                    end

                    f3SrlSra: begin
                        // Bit 30 picks arithmetic for OP and OP-IMM alike
                        if (decoded.funct7b5) begin
                            aluCtrl = ctrlSra;
                        end else begin
                            aluCtrl = ctrlSrl;
                        end
                    end

                    default: aluCtrl = ctrlAdd;
                endcase
            end

            // Unused class code, already flagged upstream
            default: aluCtrl = ctrlAdd;
        endcase
    end

endmodule

// ==== src/aluExecute.sv ====
`timescale 1ns/1ps

module aluExecute (
    input  rvIsaPkg::wordT      operandA,
    input  rvIsaPkg::wordT      operandB,
    input  aluUnitPkg::aluCtrlT aluCtrl,
    output rvIsaPkg::wordT      value,
    output aluUnitPkg::aluFlagsT flags
);

    import rvIsaPkg::*;
    import aluUnitPkg::*;

    logic        doSub;        // Adder in subtract mode
    wordT        addendB;
    logic [32:0] sumFull;      // Carry in bit 32
    wordT        sum;
    logic [4:0]  shamt;

    // Subtract, SLT and SLTU all need a - b
    assign doSub = (aluCtrl == ctrlSub) || (aluCtrl == ctrlSlt) || (aluCtrl == ctrlSltu);

    // Two's complement subtract, invert plus carry in
    assign addendB = doSub ? ~operandB : operandB;
    assign sumFull = {1'b0, operandA} + {1'b0, addendB} + {32'd0, doSub};
    assign sum     = sumFull[31:0];

    assign shamt = operandB[4:0];   // Only low five bits count

    // Flags of the shared adder
    assign flags.zero     = (sum == '0);
    assign flags.negative = sum[31];
    assign flags.carry    = sumFull[32];
    // Same input signs, result sign differs
    assign flags.overflow = (operandA[31] == addendB[31]) && (sum[31] != operandA[31]);

    always_comb begin
        case (aluCtrl)
            ctrlAdd, ctrlSub: value = sum;
            ctrlSlt:  value = {31'd0, flags.negative ^ flags.overflow};  // Signed less
            ctrlSltu: value = {31'd0, ~flags.carry};                     // Borrow out
            ctrlAnd:  value = operandA & operandB;
            ctrlOr:   value = operandA | operandB;
            ctrlXor:  value = operandA ^ operandB;
            ctrlSll:  value = operandA << shamt;
            ctrlSrl:  value = operandA >> shamt;
            ctrlSra:  value = wordT'($signed(operandA) >>> shamt);
            default:  value = sum;
        endcase
    end

endmodule

// ==== src/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req,
    input  aluUnitPkg::aluRequestT request,
    output logic                   ack,
    output aluUnitPkg::aluResultT  result
);

    import rvIsaPkg::*;
    import aluUnitPkg::*;

    aluRequestT   captured;
    decodedInstrT decoded;
    aluCtrlT      aluCtrl;
    wordT         operandB;
    wordT         value;
    aluFlagsT     flags;

    // Immediate for OP-IMM, loads and stores
    assign operandB = decoded.useImm ? decoded.imm : captured.rs2Val;

    resultStage resultStageInst (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .request  (request),
        .captured (captured),
        .decoded  (decoded),
        .value    (value),
        .flags    (flags),
        .ack      (ack),
        .result   (result)
    );

    instrDecoder instrDecoderInst (
        .request (captured),
        .decoded (decoded)
    );

    aluDecoder aluDecoderInst (
        .decoded (decoded),
        .aluCtrl (aluCtrl)
    );

    aluExecute aluExecuteInst (
        .operandA (captured.rs1Val),
        .operandB (operandB),
        .aluCtrl  (aluCtrl),
        .value    (value),
        .flags    (flags)
    );

endmodule

// ==== src/aluUnitPkg.sv ====
package aluUnitPkg;

    // Operation class from the main decoder
    typedef enum logic [1:0] {
        aluOpAdd   = 2'b00,           // Loads and stores, address add
        aluOpSub   = 2'b01,           // Branches, compare by subtract
        aluOpFunct = 2'b10            // OP and OP-IMM, funct3 decides
    } aluOpT;

    // ALU control codes
    typedef enum logic [3:0] {
        ctrlSrl  = 4'b0000,
        ctrlSra  = 4'b0001,
        ctrlAnd  = 4'b0010,
        ctrlOr   = 4'b0011,
        ctrlXor  = 4'b0100,
        ctrlSlt  = 4'b0101,
        ctrlSltu = 4'b0110,
        ctrlSll  = 4'b0111,
        ctrlAdd  = 4'b1000,
        ctrlSub  = 4'b1001
    } aluCtrlT;

    typedef struct packed {
        rvIsaPkg::wordT instr;
        rvIsaPkg::wordT rs1Val;
        rvIsaPkg::wordT rs2Val;
    } aluRequestT;

    typedef struct packed {
        aluOpT          aluOp;
        logic           useImm;       // Operand B from imm, else rs2
        rvIsaPkg::wordT imm;          // Sign-extended I or S immediate
        logic [2:0]     funct3;
        logic           op5;          // Opcode bit 5, set for OP
        logic           funct7b5;     // Instruction bit 30
        logic           isBranch;
        logic           illegal;
    } decodedInstrT;

    // Status of the add/sub path
    typedef struct packed {
        logic zero;
        logic negative;
        logic overflow;
        logic carry;                  // Set means no borrow on subtract
    } aluFlagsT;

    typedef struct packed {
        rvIsaPkg::wordT value;
        logic           branchTaken;
        logic           illegal;
    } aluResultT;

endpackage

// ==== src/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
    input  aluUnitPkg::aluRequestT   request,   // Captured request
    output aluUnitPkg::decodedInstrT decoded
);

    import rvIsaPkg::*;
    import aluUnitPkg::*;

    instrFieldsT fields;
    opcodeT      opcode;
    wordT        immI;
    wordT        immS;

    assign fields = request.instr;        // Field view of the word
    assign opcode = opcodeT'(fields.opcode);

    // Immediates, both sign-extended from bit 31
    assign immI = {{20{fields.funct7[6]}}, fields.funct7, fields.rs2};
    assign immS = {{20{fields.funct7[6]}}, fields.funct7, fields.rd};

    always_comb begin
        // Raw fields pass straight to the ALU decoder
        decoded.funct3   = fields.funct3;
        decoded.op5      = fields.opcode[5];
        decoded.funct7b5 = fields.funct7[5];

        // Defaults match an unknown opcode
        decoded.aluOp    = aluOpAdd;
        decoded.useImm   = 1'b0;
        decoded.imm      = immI;
        decoded.isBranch = 1'b0;
        decoded.illegal  = 1'b0;

        case (opcode)
            opOp: begin
                decoded.aluOp = aluOpFunct;   // Register operands
            end
            opOpImm: begin
                decoded.aluOp  = aluOpFunct;
                decoded.useImm = 1'b1;
            end
            opLoad: begin
                decoded.useImm = 1'b1;        // rs1 + I offset
            end
            opStore: begin
                decoded.useImm = 1'b1;
                decoded.imm    = immS;        // Offset split around rd field
            end
            opBranch: begin
                decoded.aluOp    = aluOpSub;
                decoded.isBranch = 1'b1;
                // Only six compare codes exist
                case (fields.funct3)
                    f3Beq, f3Bne, f3Blt, f3Bge, f3Bltu, f3Bgeu: decoded.illegal = 1'b0;
                    default: decoded.illegal = 1'b1;
                endcase
            end
            default: begin
                decoded.illegal = 1'b1;       // Outside the kept classes
            end
        endcase
    end

endmodule

// ==== src/resultStage.sv ====
`timescale 1ns/1ps

module resultStage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req,
    input  aluUnitPkg::aluRequestT   request,
    output aluUnitPkg::aluRequestT   captured,   // Held copy for the decoders
    input  aluUnitPkg::decodedInstrT decoded,
    input  rvIsaPkg::wordT           value,
    input  aluUnitPkg::aluFlagsT     flags,
    output logic                     ack,
    output aluUnitPkg::aluResultT    result
);

    import rvIsaPkg::*;
    import aluUnitPkg::*;

    typedef enum logic {
        stIdle,     // Waiting for req
        stBusy      // Request held, result pending or acked
    } stateT;

    stateT     state;
    logic      taken;
    aluResultT nextResult;

    // Branch outcome from the rs1 - rs2 flags
    always_comb begin
        case (decoded.funct3)
            f3Beq:   taken = flags.zero;
            f3Bne:   taken = ~flags.zero;
            f3Blt:   taken = flags.negative ^ flags.overflow;
            f3Bge:   taken = ~(flags.negative ^ flags.overflow);
            f3Bltu:  taken = ~flags.carry;   // Borrow means below
            f3Bgeu:  taken = flags.carry;
            default: taken = 1'b0;
        endcase
    end

    // Illegal wins over everything, branches give no value
    always_comb begin
        nextResult.illegal     = decoded.illegal;
        nextResult.branchTaken = decoded.isBranch && !decoded.illegal && taken;
        if (decoded.illegal || decoded.isBranch) begin
            nextResult.value = '0;
        end else begin
            nextResult.value = value;
        end
    end

    // Four-phase handshake control
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stIdle;
            ack   <= 1'b0;
        end else begin
            case (state)
                stIdle: if (req) state <= stBusy;   // Request captured this edge
                stBusy: begin
                    if (!ack) begin
                        ack <= 1'b1;            // Result registered alongside
                    end else if (!req) begin
                        ack   <= 1'b0;
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (state == stIdle && req) captured <= request;
        if (state == stBusy && !ack) result <= nextResult;  // Held while acked
    end

endmodule

// ==== src/rvIsaPkg.sv ====
package rvIsaPkg;

    // Base integer width
    localparam int xlen = 32;

    typedef logic [xlen-1:0] wordT;   // One data or instruction word

    // Major opcodes kept by this unit
    typedef enum logic [6:0] {
        opOp     = 7'b0110011,        // R-type ALU
        opOpImm  = 7'b0010011,        // I-type ALU
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011
    } opcodeT;

    // funct3 under OP and OP-IMM
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;   // Split by funct7 bit 5
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // funct3 under BRANCH, 010 and 011 unused
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // R-type field layout, MSB first
    // I and S immediates are rebuilt from these fields
    typedef struct packed {
        logic [6:0] funct7;           // imm[11:5] for I and S
        logic [4:0] rs2;              // imm[4:0] for I
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;               // imm[4:0] for S
        logic [6:0] opcode;
    } instrFieldsT;

endpackage

// ==== testbench/aluUnitPatterns.txt ====
# instr rs1Val rs2Val expectedValue expectedTaken expectedIllegal, all hex
# R-type: ADD SUB SLL SLT SLTU XOR SRL SRA OR AND
002081B3 7FFFFFFF 00000001 80000000 0 0
402081B3 00000005 00000007 FFFFFFFE 0 0
002091B3 00000001 0000003F 80000000 0 0
0020A1B3 80000000 00000001 00000001 0 0
0020B1B3 FFFFFFFF 00000001 00000000 0 0
0020C1B3 F0F0F0F0 0FF00FF0 FF00FF00 0 0
0020D1B3 80000000 00000004 08000000 0 0
4020D1B3 80000000 00000004 F8000000 0 0
0020E1B3 12340000 00005678 12345678 0 0
0020F1B3 FFFF0000 0F0F0F0F 0F0F0000 0 0
# I-type ALU, rs2Val must be ignored
FFF08193 00000010 DEADBEEF 0000000F 0 0
40008193 00000005 DEADBEEF 00000405 0 0
00409193 00000003 DEADBEEF 00000030 0 0
0080D193 80000000 DEADBEEF 00800000 0 0
4080D193 80000000 DEADBEEF FF800000 0 0
FFF0B193 00000005 DEADBEEF 00000001 0 0
FFF0C193 0000FF00 DEADBEEF FFFF00FF 0 0
0FF0F193 12345678 DEADBEEF 00000078 0 0
# LW and SW address, positive and negative offsets
0080A183 00001000 00000000 00001008 0 0
FFC0A183 00001000 00000000 00000FFC 0 0
0220A223 00002000 CAFEF00D 00002024 0 0
FE20AC23 00002000 CAFEF00D 00001FF8 0 0
# Branches: BEQ BNE BLT BGE BLTU BGEU
00208063 12345678 12345678 00000000 1 0
00208063 00000001 00000002 00000000 0 0
00209063 00000001 00000002 00000000 1 0
0020C063 80000000 7FFFFFFF 00000000 1 0
0020C063 7FFFFFFF 80000000 00000000 0 0
0020D063 FFFFFFFF FFFFFFFF 00000000 1 0
0020D063 FFFFFFFF 00000000 00000000 0 0
0020E063 00000000 FFFFFFFF 00000000 1 0
0020E063 FFFFFFFF FFFFFFFF 00000000 0 0
0020F063 80000000 7FFFFFFF 00000000 1 0
0020F063 00000000 00000001 00000000 0 0
# Illegal: LUI, branch funct3 010 and 011
123451B7 00000001 00000002 00000000 0 1
0020A063 00000005 00000005 00000000 0 1
0020B063 00000005 00000005 00000000 0 1

// ==== testbench/aluUnitTb.sv ====
`timescale 1ns/1ps

module aluUnitTb;

    import rvIsaPkg::*;
    import aluUnitPkg::*;

    // One transfer from the pattern file
    typedef struct packed {
        aluRequestT request;
        aluResultT  expected;
    } patternT;

    logic       clk;
    logic       rst;
    logic       req;
    aluRequestT request;
    logic       ack;
    aluResultT  result;

    patternT patterns[$];
    int      seed = 94;               // Gaps and hold times
    int      cycleCount = 0;
    int      cycleLimit = 0;          // Known once the file is read
    int      valueErrors = 0;
    int      statusErrors = 0;
    int      handshakeErrors = 0;

    clockGen clockGenInst (.clk(clk));

    aluUnit aluUnit_inst (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .request (request),
        .ack     (ack),
        .result  (result)
    );

    task automatic checkValue(input wordT actual, input wordT expected, input int idx);
        if (actual !== expected) begin
            valueErrors++;
            $display("error at %0t: pattern %0d value %h, expected %h",
                     $time, idx, actual, expected);
        end
    endtask

    // Only branchTaken and illegal are compared here
    task automatic checkStatus(input aluResultT actual, input aluResultT expected, input int idx);
        if (actual.branchTaken !== expected.branchTaken ||
            actual.illegal !== expected.illegal) begin
            statusErrors++;
            $display("error at %0t: pattern %0d taken %b illegal %b, expected taken %b illegal %b",
                     $time, idx, actual.branchTaken, actual.illegal,
                     expected.branchTaken, expected.illegal);
        end
    endtask

    task automatic handshakeFault(input string what, input int idx);
        handshakeErrors++;
        $display("Handshake problem in pattern %0d: %s", idx, what);
    endtask

    task automatic finishRun(input logic aborted);
        $display("Errors: value %0d, status %0d, handshake %0d",
                 valueErrors, statusErrors, handshakeErrors);
        if (!aborted && valueErrors + statusErrors + handshakeErrors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    task automatic loadPatterns(output logic loaded);
        int      fd;
        int      fieldCount;
        string   line;
        patternT entry;
        wordT    instr, rs1Val, rs2Val, value;
        logic    taken, illegal;
        fd = $fopen("testbench/aluUnitPatterns.txt", "r");
        loaded = (fd != 0);
        if (loaded) begin
            while (!$feof(fd)) begin
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin   // Skip blanks and comments
                    fieldCount = $sscanf(line, "%h %h %h %h %h %h",
                                         instr, rs1Val, rs2Val, value, taken, illegal);
                    if (fieldCount == 6) begin
                        entry.request  = '{instr: instr, rs1Val: rs1Val, rs2Val: rs2Val};
                        entry.expected = '{value: value, branchTaken: taken, illegal: illegal};
                        patterns.push_back(entry);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // One four-phase transfer with its checks
    task automatic runTransfer(input patternT pat, input int idx);
        int        edges;
        int        hold;
        aluResultT held;
        edges = 0;
        hold  = {$random(seed)} % 3;
        @(posedge clk);
        request <= pat.request;
        req     <= 1'b1;
        do begin
            @(negedge clk);
            edges++;
        end while (!ack);
        // Drive edge, capture edge, then the result edge
        if (edges != 3) handshakeFault("ack did not rise on the second edge that saw req", idx);
        checkValue(result.value, pat.expected.value, idx);
        checkStatus(result, pat.expected, idx);
        held = result;
        @(posedge clk);
        // Fields are free once acked
        request <= '{instr: $random(seed), rs1Val: $random(seed), rs2Val: $random(seed)};
        repeat (hold) begin
            @(negedge clk);
            if (!ack || result !== held) begin
                handshakeFault("ack or result moved while req was held", idx);
            end
            @(posedge clk);
        end
        req <= 1'b0;
        @(negedge clk);
        if (!ack) handshakeFault("ack fell before req was seen low", idx);
        if (result !== held) handshakeFault("result moved while ack was high", idx);
        @(negedge clk);
        if (ack) handshakeFault("ack did not fall on the edge after req dropped", idx);
    endtask

    // Watchdog
    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            finishRun(1'b1);
        end
    end

    initial begin
        logic loaded;
        rst     = 1'b1;
        req     = 1'b0;
        request = '0;
        loadPatterns(loaded);
        if (!loaded) begin
            $display("Could not open testbench/aluUnitPatterns.txt for reading");
            finishRun(1'b1);
        end else begin
            cycleLimit = patterns.size() * 10 + 20;   // Worst transfer is 10 cycles
            repeat (5) @(posedge clk);
            rst <= 1'b0;
            @(negedge clk);
            if (ack !== 1'b0) handshakeFault("ack is not low after reset", 0);
            foreach (patterns[i]) begin
                repeat ({$random(seed)} % 4) @(posedge clk);   // Idle gap
                runTransfer(patterns[i], i);
            end
            finishRun(1'b0);
        end
    end

endmodule

// ==== testbench/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
    output logic clk
);

    initial clk = 1'b0;
    always #10 clk = ~clk;   // Half of the 20 ns period

endmodule
